// File: ntm_defs.svh
// Shared widths and size limits for the NTM input gate trainer, included by packages and testbench
`ifndef NTM_DEFS_SVH
`define NTM_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// One element, arithmetic wraps at 2^16
`define NTM_DATA_W 16

// Unit and input index width
`define NTM_IDX_W 3

// Time step counter width
`define NTM_STEP_W 8

////////////////////////////////////////////////////////////////////////////
// Layer limits
////////////////////////////////////////////////////////////////////////////

// Largest layer the accumulator arrays can hold
`define NTM_MAX_L 8
`define NTM_MAX_X 8

// Idle cycles between the last triple of a step and the next x load
`define NTM_FLUSH_CYCLES 3

`endif

// File: ntm_arith_pkg.sv
// Datapath element, index and count types, imported by every module of the trainer
`include "ntm_defs.svh"

package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  // One data word, all sums and products taken modulo 2^16
  typedef logic [`NTM_DATA_W-1:0] elem_t;

  // Unit or input index, 0 to 7
  typedef logic [`NTM_IDX_W-1:0] idx_t;

  // Layer dimension, 1 to 8, one bit wider than an index
  typedef logic [`NTM_IDX_W:0] size_t;

  // Number of time steps in a run
  typedef logic [`NTM_STEP_W-1:0] step_t;

  // Constant one for the (1 - i) term
  localparam elem_t ELEM_ONE = elem_t'(1);

endpackage

// File: ntm_ctrl_pkg.sv
// Controller state, input phase and flush counter types for the trainer FSM
`include "ntm_defs.svh"

package ntm_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    LOAD_X,
    LOAD_GATE,
    STEP_FLUSH,
    DRAIN_W,
    DRAIN_B,
    DONE
  } trainer_state_e;

  // Which host stream a state listens to
  typedef enum logic [1:0] {
    PHASE_WAIT,
    PHASE_X,
    PHASE_GATE,
    PHASE_DRAIN
  } trainer_phase_e;

  // Pipeline drain wait between steps
  typedef logic [1:0] flush_cnt_t;
  localparam flush_cnt_t FLUSH_LAST = flush_cnt_t'(`NTM_FLUSH_CYCLES - 1);

  // Map a state to the stream it accepts
  function automatic trainer_phase_e phase_of(trainer_state_e s);
    case (s)
      LOAD_X:           return PHASE_X;
      LOAD_GATE:        return PHASE_GATE;
      DRAIN_W, DRAIN_B: return PHASE_DRAIN;
      default:          return PHASE_WAIT;
    endcase
  endfunction

endpackage

// File: ntm_trainer_controller.sv
// Phase FSM of the input gate trainer, gating host strobes and sequencing the result drain
`timescale 1ns/1ps

module ntm_trainer_controller (
  input  logic                 CLK,
  input  logic                 RST,

  // Host control
  input  logic                 START,
  input  logic                 X_IN_ENABLE,
  input  logic                 GATE_IN_ENABLE,
  input  ntm_arith_pkg::size_t SIZE_L_IN,
  input  ntm_arith_pkg::size_t SIZE_X_IN,
  input  ntm_arith_pkg::step_t SIZE_T_IN,
  output logic                 READY,

  // Accumulator control
  output logic                 clear,
  output logic                 x_we,
  output ntm_arith_pkg::idx_t  x_idx,

  // Delta pipeline feed
  output logic                 gate_valid,
  output ntm_arith_pkg::idx_t  gate_idx,

  // Drain addressing
  output logic                 rd_w,
  output logic                 rd_b,
  output ntm_arith_pkg::idx_t  rd_l,
  output ntm_arith_pkg::idx_t  rd_x
);

  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  trainer_state_e state;
  trainer_phase_e phase;

  // Last valid index per dimension, latched on START
  idx_t       last_l;
  idx_t       last_x;
  step_t      last_step;

  // Running counters
  step_t      step_cnt;
  idx_t       elem_cnt;
  idx_t       row_cnt;
  flush_cnt_t flush_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe gating
  ////////////////////////////////////////////////////////////////////////////

  assign phase = phase_of(state);

  // Accumulators zeroed on the accept cycle
  assign clear = START && (state == IDLE);

  // Strobes outside their phase simply dropped
  assign x_we       = X_IN_ENABLE && (phase == PHASE_X);
  assign x_idx      = elem_cnt;
  assign gate_valid = GATE_IN_ENABLE && (phase == PHASE_GATE);
  assign gate_idx   = elem_cnt;

  // Row-major drain, column from elem_cnt
  assign rd_w = (state == DRAIN_W);
  assign rd_b = (state == DRAIN_B);
  assign rd_l = row_cnt;
  assign rd_x = elem_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      last_l    <= '0;
      last_x    <= '0;
      last_step <= '0;
      step_cnt  <= '0;
      elem_cnt  <= '0;
      row_cnt   <= '0;
      flush_cnt <= '0;
      READY     <= 1'b0;
    end else begin
      // One cycle after DONE, i.e. one after the last B beat
      READY <= (state == DONE);

      case (state)
        IDLE: begin
          if (START) begin
            last_l    <= idx_t'(SIZE_L_IN - size_t'(1));
            last_x    <= idx_t'(SIZE_X_IN - size_t'(1));
            last_step <= SIZE_T_IN - step_t'(1);
            step_cnt  <= '0;
            elem_cnt  <= '0;
            row_cnt   <= '0;
            state     <= LOAD_X;
          end
        end

        LOAD_X: begin
          if (x_we) begin
            if (elem_cnt == last_x) begin
              elem_cnt <= '0;
              state    <= LOAD_GATE;
            end else begin
              elem_cnt <= elem_cnt + idx_t'(1);
            end
          end
        end

        LOAD_GATE: begin
          if (gate_valid) begin
            if (elem_cnt == last_l) begin
              elem_cnt  <= '0;
              flush_cnt <= '0;
              state     <= STEP_FLUSH;
            end else begin
              elem_cnt <= elem_cnt + idx_t'(1);
            end
          end
        end

        // Let the two-stage delta pipeline empty before x is overwritten
        STEP_FLUSH: begin
          if (flush_cnt == FLUSH_LAST) begin
            if (step_cnt == last_step) begin
              row_cnt <= '0;
              state   <= DRAIN_W;
            end else begin
              step_cnt <= step_cnt + step_t'(1);
              state    <= LOAD_X;
            end
          end else begin
            flush_cnt <= flush_cnt + flush_cnt_t'(1);
          end
        end

        DRAIN_W: begin
          if (elem_cnt == last_x) begin
            elem_cnt <= '0;
            if (row_cnt == last_l) begin
              row_cnt <= '0;
              state   <= DRAIN_B;
            end else begin
              row_cnt <= row_cnt + idx_t'(1);
            end
          end else begin
            elem_cnt <= elem_cnt + idx_t'(1);
          end
        end

        DRAIN_B: begin
          if (row_cnt == last_l) begin
            state <= DONE;
          end else begin
            row_cnt <= row_cnt + idx_t'(1);
          end
        end

        // Last B beat leaves the accumulator here
        DONE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: ntm_gate_delta.sv
// Two-stage pipeline forming the input gate delta di = ds*a*i*(1-i) per streamed triple
`timescale 1ns/1ps

module ntm_gate_delta (
  input  logic                 CLK,
  input  logic                 RST,

  // Accepted triple
  input  logic                 gate_valid,
  input  ntm_arith_pkg::idx_t  gate_idx,
  input  ntm_arith_pkg::elem_t A_IN,
  input  ntm_arith_pkg::elem_t I_IN,
  input  ntm_arith_pkg::elem_t S_IN,

  // Delta out, two cycles later
  output logic                 di_valid,
  output ntm_arith_pkg::elem_t di,
  output ntm_arith_pkg::idx_t  di_idx
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////////////////////////////////////////

  logic  s1_valid;
  idx_t  s1_idx;
  elem_t s1_ds_a;
  // Sigmoid slope term
  elem_t s1_slope;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      di_valid <= 1'b0;
    end else begin
      s1_valid <= gate_valid;
      di_valid <= s1_valid;
    end
  end

  // Products truncated to 16 bits by the target width
  always_ff @(posedge CLK) begin
    s1_idx   <= gate_idx;
    s1_ds_a  <= S_IN * A_IN;
    // Wraps when i > 1
    s1_slope <= I_IN * (ELEM_ONE - I_IN);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    di_idx <= s1_idx;
    di     <= s1_ds_a * s1_slope;
  end

endmodule

// File: ntm_gradient_accumulator.sv
// Step input buffer plus dW and db accumulators, with the registered drain read port
`timescale 1ns/1ps
`include "ntm_defs.svh"

module ntm_gradient_accumulator (
  input  logic                 CLK,
  input  logic                 RST,

  // Run control
  input  logic                 clear,

  // Input vector write
  input  logic                 x_we,
  input  ntm_arith_pkg::idx_t  x_idx,
  input  ntm_arith_pkg::elem_t X_IN,

  // Delta from pipeline
  input  logic                 di_valid,
  input  ntm_arith_pkg::elem_t di,
  input  ntm_arith_pkg::idx_t  di_idx,

  // Drain read
  input  logic                 rd_w,
  input  logic                 rd_b,
  input  ntm_arith_pkg::idx_t  rd_l,
  input  ntm_arith_pkg::idx_t  rd_x,
  output ntm_arith_pkg::elem_t W_OUT,
  output ntm_arith_pkg::elem_t B_OUT,
  output logic                 W_OUT_ENABLE,
  output logic                 B_OUT_ENABLE
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // x of the current step
  elem_t x_buf  [`NTM_MAX_X];

  // Gradients summed over all steps
  elem_t dw_acc [`NTM_MAX_L][`NTM_MAX_X];
  elem_t db_acc [`NTM_MAX_L];

  // di * x[j] for the whole row at once
  elem_t di_x   [`NTM_MAX_X];

  ////////////////////////////////////////////////////////////////////////////
  // Input buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (x_we) begin
      x_buf[x_idx] <= X_IN;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Accumulation
  ////////////////////////////////////////////////////////////////////////////

  // One multiplier per column
  always_comb begin
    for (int j = 0; j < `NTM_MAX_X; j++) begin
      di_x[j] = di * x_buf[j];
    end
  end

  // Whole dW row and one db entry per delta
  always_ff @(posedge CLK) begin
    if (clear) begin
      for (int l = 0; l < `NTM_MAX_L; l++) begin
        db_acc[l] <= '0;
        for (int j = 0; j < `NTM_MAX_X; j++) begin
          dw_acc[l][j] <= '0;
        end
      end
    end else if (di_valid) begin
      db_acc[di_idx] <= db_acc[di_idx] + di;
      for (int j = 0; j < `NTM_MAX_X; j++) begin
        dw_acc[di_idx][j] <= dw_acc[di_idx][j] + di_x[j];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drain port
  ////////////////////////////////////////////////////////////////////////////

  // Enables one cycle behind the strobes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      W_OUT_ENABLE <= 1'b0;
      B_OUT_ENABLE <= 1'b0;
    end else begin
      W_OUT_ENABLE <= rd_w;
      B_OUT_ENABLE <= rd_b;
    end
  end

  // Data aligned with the enables
  always_ff @(posedge CLK) begin
    if (rd_w) begin
      W_OUT <= dw_acc[rd_l][rd_x];
    end
    if (rd_b) begin
      B_OUT <= db_acc[rd_l];
    end
  end

endmodule

// File: ntm_input_trainer.sv
// Top level of the NTM input gate trainer peripheral, wiring controller, delta pipeline and accumulator
`timescale 1ns/1ps

module ntm_input_trainer (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,
  input  logic                 X_IN_ENABLE,
  input  logic                 GATE_IN_ENABLE,

  // Layer dimensions
  input  ntm_arith_pkg::size_t SIZE_L_IN,
  input  ntm_arith_pkg::size_t SIZE_X_IN,
  input  ntm_arith_pkg::step_t SIZE_T_IN,

  // Streamed operands
  input  ntm_arith_pkg::elem_t X_IN,
  input  ntm_arith_pkg::elem_t A_IN,
  input  ntm_arith_pkg::elem_t I_IN,
  input  ntm_arith_pkg::elem_t S_IN,

  // Gradients out
  output ntm_arith_pkg::elem_t W_OUT,
  output ntm_arith_pkg::elem_t B_OUT,
  output logic                 W_OUT_ENABLE,
  output logic                 B_OUT_ENABLE
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  // Controller to accumulator
  logic  clear;
  logic  x_we;
  idx_t  x_idx;
  logic  rd_w;
  logic  rd_b;
  idx_t  rd_l;
  idx_t  rd_x;

  // Controller to delta pipeline
  logic  gate_valid;
  idx_t  gate_idx;

  // Delta pipeline to accumulator
  logic  di_valid;
  elem_t di;
  idx_t  di_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  ntm_trainer_controller ntm_trainer_controller_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .X_IN_ENABLE    (X_IN_ENABLE),
    .GATE_IN_ENABLE (GATE_IN_ENABLE),
    .SIZE_L_IN      (SIZE_L_IN),
    .SIZE_X_IN      (SIZE_X_IN),
    .SIZE_T_IN      (SIZE_T_IN),
    .READY          (READY),
    .clear          (clear),
    .x_we           (x_we),
    .x_idx          (x_idx),
    .gate_valid     (gate_valid),
    .gate_idx       (gate_idx),
    .rd_w           (rd_w),
    .rd_b           (rd_b),
    .rd_l           (rd_l),
    .rd_x           (rd_x)
  );

  // di two cycles after each accepted triple
  ntm_gate_delta ntm_gate_delta_i (
    .CLK        (CLK),
    .RST        (RST),
    .gate_valid (gate_valid),
    .gate_idx   (gate_idx),
    .A_IN       (A_IN),
    .I_IN       (I_IN),
    .S_IN       (S_IN),
    .di_valid   (di_valid),
    .di         (di),
    .di_idx     (di_idx)
  );

  ntm_gradient_accumulator ntm_gradient_accumulator_i (
    .CLK          (CLK),
    .RST          (RST),
    .clear        (clear),
    .x_we         (x_we),
    .x_idx        (x_idx),
    .X_IN         (X_IN),
    .di_valid     (di_valid),
    .di           (di),
    .di_idx       (di_idx),
    .rd_w         (rd_w),
    .rd_b         (rd_b),
    .rd_l         (rd_l),
    .rd_x         (rd_x),
    .W_OUT        (W_OUT),
    .B_OUT        (B_OUT),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .B_OUT_ENABLE (B_OUT_ENABLE)
  );

endmodule

// File: ntm_input_trainer_tb.sv
// Self-checking testbench that runs the NTM input gate trainer through directed and random layers
`timescale 1ns/1ps
`include "ntm_defs.svh"

module ntm_input_trainer_tb;

  import ntm_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Run length bound
  ////////////////////////////////////////////////////////////////////////////

  // Generous cycle count of one run, stray strobes and flush included
  function automatic int test_cycles(int l, int x, int t);
    return t * (2 * x + 2 * l + `NTM_FLUSH_CYCLES + 2) + l * x + l + 8;
  endfunction

  // Reset, six tests, idle watch after the mid-run reset, margin
  localparam int CYCLE_LIMIT = 16 + test_cycles(1, 1, 1) + test_cycles(8, 8, 4) +
    4 * test_cycles(4, 4, 2) + test_cycles(3, 5, 3) + test_cycles(4, 4, 1) + 30 + 200;

  localparam int MAX_T = 8;

  ////////////////////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////////////////////

  logic  CLK = 1'b0;
  logic  RST;
  logic  START;
  logic  READY;
  logic  X_IN_ENABLE;
  logic  GATE_IN_ENABLE;
  size_t SIZE_L_IN;
  size_t SIZE_X_IN;
  step_t SIZE_T_IN;
  elem_t X_IN;
  elem_t A_IN;
  elem_t I_IN;
  elem_t S_IN;
  elem_t W_OUT;
  elem_t B_OUT;
  logic  W_OUT_ENABLE;
  logic  B_OUT_ENABLE;

  always #20 CLK = ~CLK;

  ntm_input_trainer ntm_input_trainer_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .X_IN_ENABLE    (X_IN_ENABLE),
    .GATE_IN_ENABLE (GATE_IN_ENABLE),
    .SIZE_L_IN      (SIZE_L_IN),
    .SIZE_X_IN      (SIZE_X_IN),
    .SIZE_T_IN      (SIZE_T_IN),
    .X_IN           (X_IN),
    .A_IN           (A_IN),
    .I_IN           (I_IN),
    .S_IN           (S_IN),
    .W_OUT          (W_OUT),
    .B_OUT          (B_OUT),
    .W_OUT_ENABLE   (W_OUT_ENABLE),
    .B_OUT_ENABLE   (B_OUT_ENABLE)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus store and run state
  ////////////////////////////////////////////////////////////////////////////

  // Indexed [step][input] and [step][unit]
  elem_t stim_x [MAX_T][`NTM_MAX_X];
  elem_t stim_a [MAX_T][`NTM_MAX_L];
  elem_t stim_i [MAX_T][`NTM_MAX_L];
  elem_t stim_s [MAX_T][`NTM_MAX_L];

  int    cur_l = 1;
  int    cur_x = 1;
  int    cur_t = 1;
  int    run_id = 0;
  bit    expect_out = 1'b0;

  // Monitor side
  int    seen_run = 0;
  int    mon_cycle = 0;
  int    w_cnt = 0;
  int    b_cnt = 0;
  int    ready_cnt = 0;
  int    first_w = 0;
  int    mon_errors = 0;

  // Sequencer side
  int    run_errors = 0;
  int    err_before = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name;
  logic [15:0] lfsr_state = 16'd64;

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("ERROR: run stopped after %0d cycles without finishing", cycle_cnt);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random operands
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      r = {r[14:0], lfsr_state[15]};
      lfsr_state = {lfsr_state[14:0], fb};
    end
    return r;
  endfunction

  // Near 2^16 for the wrap test
  function automatic elem_t draw_operand(bit near_wrap);
    if (near_wrap) begin
      return 16'hFF00 | rand_bits(8);
    end
    return rand_bits(16);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Beat k of the drain, dW row-major first, then db
  function automatic elem_t expected_beat(int k);
    elem_t sum;
    elem_t di;
    idx_t  row;
    idx_t  col;
    bit    is_bias;
    sum = '0;
    is_bias = (k >= cur_l * cur_x);
    row = is_bias ? idx_t'(k - cur_l * cur_x) : idx_t'(k / cur_x);
    col = idx_t'(k % cur_x);
    for (int t = 0; t < cur_t; t++) begin
      idx_t ts;
      ts = idx_t'(t);
      // ds * a * i * (1 - i), all modulo 2^16
      di = stim_s[ts][row] * stim_a[ts][row] * stim_i[ts][row] *
           (elem_t'(1) - stim_i[ts][row]);
      if (is_bias) begin
        sum = sum + di;
      end else begin
        sum = sum + di * stim_x[ts][col];
      end
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_beat(input string name, input int beat, input elem_t got,
                              input elem_t exp);
    assert (got === exp) else begin
      $display("mismatch %s beat %0d: expected 0x%04h, got 0x%04h", name, beat, exp, got);
      mon_errors++;
    end
  endtask

  // Sampled mid-cycle, away from the edge that moves the outputs
  always @(negedge CLK) begin
    mon_cycle = mon_cycle + 1;
    if (run_id != seen_run) begin
      seen_run  = run_id;
      w_cnt     = 0;
      b_cnt     = 0;
      ready_cnt = 0;
      first_w   = 0;
    end
    if (!expect_out) begin
      assert (W_OUT_ENABLE !== 1'b1 && B_OUT_ENABLE !== 1'b1 && READY !== 1'b1) else begin
        $display("ERROR: output activity at cycle %0d with no run active", mon_cycle);
        mon_errors++;
      end
    end else begin
      if (W_OUT_ENABLE === 1'b1) begin
        if (w_cnt == 0) begin
          first_w = mon_cycle;
        end
        assert (b_cnt == 0 && w_cnt < cur_l * cur_x) else begin
          $display("ERROR: extra W_OUT beat %0d beyond the expected framing", w_cnt);
          mon_errors++;
        end
        assert (mon_cycle == first_w + w_cnt) else begin
          $display("ERROR: W_OUT beats not consecutive at beat %0d", w_cnt);
          mon_errors++;
        end
        if (w_cnt < cur_l * cur_x) begin
          compare_beat("W_OUT", w_cnt, W_OUT, expected_beat(w_cnt));
        end
        w_cnt++;
      end
      if (B_OUT_ENABLE === 1'b1) begin
        assert (w_cnt == cur_l * cur_x && b_cnt < cur_l) else begin
          $display("ERROR: B_OUT beat %0d before all W beats or beyond L", b_cnt);
          mon_errors++;
        end
        assert (mon_cycle == first_w + cur_l * cur_x + b_cnt) else begin
          $display("ERROR: B_OUT beat %0d does not directly follow the W beats", b_cnt);
          mon_errors++;
        end
        if (b_cnt < cur_l) begin
          compare_beat("B_OUT", b_cnt, B_OUT, expected_beat(cur_l * cur_x + b_cnt));
        end
        b_cnt++;
      end
      if (READY === 1'b1) begin
        assert (ready_cnt == 0 && b_cnt == cur_l &&
                mon_cycle == first_w + cur_l * cur_x + cur_l) else begin
          $display("ERROR: READY at cycle %0d is not one cycle after the last B beat",
                   mon_cycle);
          mon_errors++;
        end
        ready_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////////////////////

  // Strobes low by default, 1 ns after the edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
    START          = 1'b0;
    X_IN_ENABLE    = 1'b0;
    GATE_IN_ENABLE = 1'b0;
  endtask

  task automatic make_random_stimulus(input bit near_wrap);
    for (int t = 0; t < cur_t; t++) begin
      for (int j = 0; j < cur_x; j++) begin
        stim_x[idx_t'(t)][idx_t'(j)] = draw_operand(near_wrap);
      end
      for (int l = 0; l < cur_l; l++) begin
        stim_a[idx_t'(t)][idx_t'(l)] = draw_operand(near_wrap);
        stim_i[idx_t'(t)][idx_t'(l)] = draw_operand(near_wrap);
        stim_s[idx_t'(t)][idx_t'(l)] = draw_operand(near_wrap);
      end
    end
  endtask

  task automatic begin_run(input int l, input int x, input int t);
    cur_l      = l;
    cur_x      = x;
    cur_t      = t;
    run_id     = run_id + 1;
    expect_out = 1'b1;
  endtask

  // Back-to-back x and gate strobes, optional out-of-phase strobes with junk data
  task automatic run_stimulus(input bit stray);
    next_cycle();
    START     = 1'b1;
    SIZE_L_IN = size_t'(cur_l);
    SIZE_X_IN = size_t'(cur_x);
    SIZE_T_IN = step_t'(cur_t);
    for (int t = 0; t < cur_t; t++) begin
      for (int j = 0; j < cur_x; j++) begin
        if (stray && (j % 2 == 1)) begin
          next_cycle();
          GATE_IN_ENABLE = 1'b1;
          A_IN = rand_bits(16);
          I_IN = rand_bits(16);
          S_IN = rand_bits(16);
        end
        next_cycle();
        X_IN_ENABLE = 1'b1;
        X_IN = stim_x[idx_t'(t)][idx_t'(j)];
        // Gate strobe in LOAD_X, ignored
        GATE_IN_ENABLE = stray;
      end
      for (int l = 0; l < cur_l; l++) begin
        if (stray && (l % 2 == 1)) begin
          next_cycle();
          X_IN_ENABLE = 1'b1;
          X_IN = rand_bits(16);
        end
        next_cycle();
        GATE_IN_ENABLE = 1'b1;
        A_IN = stim_a[idx_t'(t)][idx_t'(l)];
        I_IN = stim_i[idx_t'(t)][idx_t'(l)];
        S_IN = stim_s[idx_t'(t)][idx_t'(l)];
        if (stray) begin
          X_IN_ENABLE = 1'b1;
          X_IN = rand_bits(16);
        end
      end
      // STEP_FLUSH, no strobes allowed
      repeat (`NTM_FLUSH_CYCLES) next_cycle();
    end
  endtask

  // Wait for READY, then check the framing counts
  task automatic close_run();
    while (READY !== 1'b1) begin
      @(posedge CLK);
      #1;
    end
    @(negedge CLK);
    #1;
    assert (w_cnt == cur_l * cur_x && b_cnt == cur_l && ready_cnt == 1) else begin
      $display("ERROR: run gave %0d W beats, %0d B beats, %0d READY pulses",
               w_cnt, b_cnt, ready_cnt);
      $display("ERROR: expected %0d W beats, %0d B beats and one READY pulse",
               cur_l * cur_x, cur_l);
      run_errors++;
    end
    expect_out = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    err_before = mon_errors + run_errors;
  endtask

  task automatic end_test();
    int errs;
    errs = mon_errors + run_errors - err_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, test_name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST            = 1'b1;
    START          = 1'b0;
    X_IN_ENABLE    = 1'b0;
    GATE_IN_ENABLE = 1'b0;
    SIZE_L_IN      = '0;
    SIZE_X_IN      = '0;
    SIZE_T_IN      = '0;
    X_IN           = '0;
    A_IN           = '0;
    I_IN           = '0;
    S_IN           = '0;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Hand-worked delta 21 * (5 * -4) = -420
    start_test("single step L1 X1");
    begin_run(1, 1, 1);
    stim_x[0][0] = 16'd1;
    stim_a[0][0] = 16'd3;
    stim_i[0][0] = 16'd5;
    stim_s[0][0] = 16'd7;
    assert (expected_beat(0) == 16'hFE5C) else begin
      $display("ERROR: reference model gives 0x%04h for the hand-worked delta",
               expected_beat(0));
      run_errors++;
    end
    run_stimulus(1'b0);
    close_run();
    end_test();

    start_test("full size L8 X8 T4 random");
    begin_run(8, 8, 4);
    make_random_stimulus(1'b0);
    run_stimulus(1'b0);
    close_run();
    end_test();

    // i > 1 so (1 - i) wraps too
    start_test("operands near 2^16");
    begin_run(4, 4, 2);
    make_random_stimulus(1'b1);
    run_stimulus(1'b0);
    close_run();
    end_test();

    start_test("stray strobes out of phase");
    begin_run(3, 5, 3);
    make_random_stimulus(1'b0);
    run_stimulus(1'b1);
    close_run();
    end_test();

    // Second run must not see the first run's sums
    start_test("two runs back to back");
    begin_run(4, 4, 2);
    make_random_stimulus(1'b0);
    run_stimulus(1'b0);
    close_run();
    begin_run(4, 4, 1);
    make_random_stimulus(1'b0);
    run_stimulus(1'b0);
    close_run();
    end_test();

    // Reset in the middle of the W drain
    start_test("reset mid run");
    begin_run(4, 4, 2);
    make_random_stimulus(1'b0);
    run_stimulus(1'b0);
    while (w_cnt < 5) begin
      @(posedge CLK);
      #1;
    end
    RST        = 1'b1;
    expect_out = 1'b0;
    repeat (4) next_cycle();
    RST = 1'b0;
    // Outputs must stay quiet with no START
    repeat (20) next_cycle();
    begin_run(4, 4, 2);
    make_random_stimulus(1'b0);
    run_stimulus(1'b0);
    close_run();
    end_test();

    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, mon_errors + run_errors);
    if (mon_errors + run_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
ntm_arith_pkg.sv
ntm_ctrl_pkg.sv
ntm_trainer_controller.sv
ntm_gate_delta.sv
ntm_gradient_accumulator.sv
ntm_input_trainer.sv
ntm_input_trainer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the NTM input gate trainer testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass line.

LOG=sim.log
BIN=ntm_input_trainer_sim

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ntm_input_trainer_tb -f sources.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
